// File: hdl/id_pkg.sv
/*
 Decode stage shared definitions: widths, opcode and unit operation
 encodings, and the slot structures passed between fetch, decode and rename
*/
`default_nettype none

package id_pkg;

   // Machine widths
   localparam int issue_w = 2;
   localparam int cnt_w   = 2;
   localparam int insn_w  = 32;
   localparam int dw      = 32;
   localparam int pc_w    = 30;
   localparam int lrf_aw  = 5;

   // Long-latency unit options for this build
   localparam bit enable_mul = 1'b1;
   localparam bit enable_div = 1'b0;

   // Primary opcode, bits 5..0
   typedef enum logic [5:0] {
      OP_ADD     = 6'h01,
      OP_SUB     = 6'h02,
      OP_AND     = 6'h03,
      OP_OR      = 6'h04,
      OP_XOR     = 6'h05,
      OP_ADDI    = 6'h06,
      OP_MUL     = 6'h07,
      OP_DIV     = 6'h08,
      OP_LDW     = 6'h09,
      OP_STW     = 6'h0a,
      OP_BEQ     = 6'h0b,
      OP_JAL     = 6'h0c,
      OP_SYSCALL = 6'h0d,
      OP_ERET    = 6'h0e
   } opcode_e;

   typedef enum logic [2:0] {ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;
   typedef enum logic [1:0] {LPU_NONE, LPU_MUL, LPU_DIV} lpu_op_e;
   typedef enum logic [2:0] {
      EPU_NONE, EPU_SYSCALL, EPU_ERET, EPU_EXC_FETCH, EPU_EXC_ILLEGAL, EPU_IRQ
   } epu_op_e;
   typedef enum logic [1:0] {BRU_NONE, BRU_BEQ, BRU_JAL} bru_op_e;
   typedef enum logic [1:0] {LSU_NONE, LSU_LDW, LSU_STW} lsu_op_e;

   // One slot as presented by the fetch queue
   typedef struct packed {
      logic              valid;
      logic [insn_w-1:0] ins;
      logic [pc_w-1:0]   pc;
      logic              exc;
   } fnt_slot_t;

   // Decoder result for one slot
   typedef struct packed {
      alu_op_e           alu_op;
      lpu_op_e           lpu_op;
      epu_op_e           epu_op;
      bru_op_e           bru_op;
      lsu_op_e           lsu_op;
      logic [dw-1:0]     imm;
      logic [lrf_aw-1:0] lrs1;
      logic              lrs1_re;
      logic [lrf_aw-1:0] lrs2;
      logic              lrs2_re;
      logic [lrf_aw-1:0] lrd;
      logic              lrd_we;
   } dec_slot_t;

   // Registered slot toward rename
   typedef struct packed {
      logic            valid;
      logic [pc_w-1:0] pc;
      dec_slot_t       dec;
   } rn_slot_t;

endpackage

`default_nettype wire

// File: hdl/id_dec.sv
/*
 Single-slot instruction decoder. Maps the opcode to one functional unit
 operation and its operands, then folds in interrupt and exceptions
*/
`timescale 1ns/100ps
`default_nettype none

module id_dec
(
   input  id_pkg::fnt_slot_t slot,
   input  logic              irq_async,
   output id_pkg::dec_slot_t dec
);
   import id_pkg::*;

   opcode_e           opc;
   logic              illegal;
   logic              take_exc;
   logic [lrf_aw-1:0] f_rd;
   logic [lrf_aw-1:0] f_rs1;
   logic [lrf_aw-1:0] f_rs2;
   logic [dw-1:0]     imm16_sx;
   logic [dw-1:0]     imm26_sx;

   // Fixed instruction fields
   assign opc   = opcode_e'(slot.ins[5:0]);
   assign f_rd  = slot.ins[10:6];
   assign f_rs1 = slot.ins[15:11];
   assign f_rs2 = slot.ins[20:16];

   assign imm16_sx = {{(dw-16){slot.ins[31]}}, slot.ins[31:16]};
   assign imm26_sx = {{(dw-26){slot.ins[31]}}, slot.ins[31:6]};

   always_comb
   begin
      dec.alu_op  = ALU_NONE;
      dec.lpu_op  = LPU_NONE;
      dec.epu_op  = EPU_NONE;
      dec.bru_op  = BRU_NONE;
      dec.lsu_op  = LSU_NONE;
      dec.imm     = '0;
      dec.lrs1    = f_rs1;
      dec.lrs1_re = 1'b0;
      dec.lrs2    = f_rs2;
      dec.lrs2_re = 1'b0;
      dec.lrd     = f_rd;
      dec.lrd_we  = 1'b0;
      illegal     = 1'b0;

      // Operand format
      case (opc)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL, OP_DIV:
         begin
            dec.lrs1_re = 1'b1;
            dec.lrs2_re = 1'b1;
            dec.lrd_we  = 1'b1;
         end
         OP_ADDI, OP_LDW:
         begin
            dec.lrs1_re = 1'b1;
            dec.lrd_we  = 1'b1;
            dec.imm     = imm16_sx;
         end
         // Second source sits in the rd field
         OP_STW, OP_BEQ:
         begin
            dec.lrs1_re = 1'b1;
            dec.lrs2    = f_rd;
            dec.lrs2_re = 1'b1;
            dec.imm     = imm16_sx;
         end
         OP_JAL:
         begin
            dec.lrd    = lrf_aw'(1);
            dec.lrd_we = 1'b1;
            dec.imm    = imm26_sx;
         end
         OP_SYSCALL, OP_ERET:
         begin
            dec.imm = '0;
         end
         default:
         begin
            illegal = 1'b1;
         end
      endcase

      // Unit operation
      case (opc)
         OP_ADD, OP_ADDI: dec.alu_op = ALU_ADD;
         OP_SUB:          dec.alu_op = ALU_SUB;
         OP_AND:          dec.alu_op = ALU_AND;
         OP_OR:           dec.alu_op = ALU_OR;
         OP_XOR:          dec.alu_op = ALU_XOR;
         OP_MUL:
         begin
            if (enable_mul)
               dec.lpu_op = LPU_MUL;
            else
               illegal = 1'b1;
         end
         OP_DIV:
         begin
            if (enable_div)
               dec.lpu_op = LPU_DIV;
            else
               illegal = 1'b1;
         end
         OP_LDW:          dec.lsu_op = LSU_LDW;
         OP_STW:          dec.lsu_op = LSU_STW;
         OP_BEQ:          dec.bru_op = BRU_BEQ;
         OP_JAL:          dec.bru_op = BRU_JAL;
         OP_SYSCALL:      dec.epu_op = EPU_SYSCALL;
         OP_ERET:         dec.epu_op = EPU_ERET;
         default:         dec.epu_op = EPU_NONE;
      endcase

      // r0 is hardwired, never written
      if (dec.lrd == '0)
         dec.lrd_we = 1'b0;

      // Interrupt first, then fetch fault, then illegal opcode
      take_exc = irq_async | slot.exc | illegal;
      if (take_exc | ~slot.valid)
      begin
         dec.alu_op  = ALU_NONE;
         dec.lpu_op  = LPU_NONE;
         dec.bru_op  = BRU_NONE;
         dec.lsu_op  = LSU_NONE;
         dec.lrs1_re = 1'b0;
         dec.lrs2_re = 1'b0;
         dec.lrd_we  = 1'b0;
         if (~slot.valid)
            dec.epu_op = EPU_NONE;
         else if (irq_async)
            dec.epu_op = EPU_IRQ;
         else if (slot.exc)
            dec.epu_op = EPU_EXC_FETCH;
         else
            dec.epu_op = EPU_EXC_ILLEGAL;
      end
   end

endmodule

`default_nettype wire

// File: hdl/id_pipe_reg.sv
/*
 Decode to rename stage register. Valid bits reset and clear on flush,
 payload loads whenever rename is not stalling
*/
`timescale 1ns/100ps
`default_nettype none

module id_pipe_reg
(
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  logic                                           flush,
   input  logic                                           stall,
   input  logic [id_pkg::issue_w-1:0]                     valid_in,
   input  logic [id_pkg::issue_w-1:0][id_pkg::pc_w-1:0]   pc_in,
   input  id_pkg::dec_slot_t [id_pkg::issue_w-1:0]        dec_in,
   output id_pkg::rn_slot_t [id_pkg::issue_w-1:0]         rn
);
   import id_pkg::*;

   logic [issue_w-1:0]           valid_q;
   logic [issue_w-1:0][pc_w-1:0] pc_q;
   dec_slot_t [issue_w-1:0]      dec_q;

   // Flush wins over stall
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         valid_q <= '0;
      else if (flush)
         valid_q <= '0;
      else if (!stall)
         valid_q <= valid_in;
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         pc_q  <= pc_in;
         dec_q <= dec_in;
      end
   end

   always_comb
   begin
      for (int i = 0; i < issue_w; i++)
      begin
         rn[i].valid = valid_q[i];
         rn[i].pc    = pc_q[i];
         rn[i].dec   = dec_q[i];
      end
   end

endmodule

`default_nettype wire

// File: hdl/id_stage.sv
/*
 Two-wide decode stage. One decoder per slot, consumed count back to the
 fetch queue, and the stage register toward rename
*/
`timescale 1ns/100ps
`default_nettype none

module id_stage
(
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    flush,
   input  logic                                    rn_stall_req,
   input  logic                                    irq_async,
   input  id_pkg::fnt_slot_t [id_pkg::issue_w-1:0] fnt,
   output logic [id_pkg::cnt_w-1:0]                id_pop_cnt,
   output id_pkg::rn_slot_t [id_pkg::issue_w-1:0]  rn
);
   import id_pkg::*;

   logic [issue_w-1:0]           fnt_valid;
   logic [issue_w-1:0][pc_w-1:0] fnt_pc;
   dec_slot_t [issue_w-1:0]      dec;

   genvar i;

   generate
      for (i = 0; i < issue_w; i++)
      begin : gen_dec
         // Interrupt is taken ahead of the oldest slot only
         id_dec u_dec
         (
            .slot      (fnt[i]),
            .irq_async ((i == 0) ? irq_async : 1'b0),
            .dec       (dec[i])
         );

         assign fnt_valid[i] = fnt[i].valid;
         assign fnt_pc[i]    = fnt[i].pc;
      end
   endgenerate

   // Slots consumed this cycle, none while rename stalls
   always_comb
   begin
      id_pop_cnt = '0;
      for (int k = 0; k < issue_w; k++)
      begin
         id_pop_cnt = id_pop_cnt + cnt_w'(fnt_valid[k] & ~rn_stall_req);
      end
   end

   id_pipe_reg u_pipe_reg
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (flush),
      .stall    (rn_stall_req),
      .valid_in (fnt_valid),
      .pc_in    (fnt_pc),
      .dec_in   (dec),
      .rn       (rn)
   );

endmodule

`default_nettype wire

// File: test/id_tb_clk.sv
/*
 Free-running testbench clock with a 10 ns period
*/
`timescale 1ns/100ps
`default_nettype none

module id_tb_clk
(
   output logic clk
);
   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

endmodule

`default_nettype wire

// File: test/id_stage_chk.sv
/*
 Bound checks on the decode stage: consumed count under stall, valid
 clearing after flush or reset, and one unit op per valid rename slot
*/
`timescale 1ns/100ps
`default_nettype none

module id_stage_chk
(
   input logic                                   clk,
   input logic                                   rst_n,
   input logic                                   flush,
   input logic                                   rn_stall_req,
   input logic [id_pkg::cnt_w-1:0]               id_pop_cnt,
   input id_pkg::rn_slot_t [id_pkg::issue_w-1:0] rn
);
   import id_pkg::*;

   int                      fails = 0;
   logic [issue_w-1:0]      rn_valid;
   logic [issue_w-1:0][2:0] op_cnt;

   always_comb
   begin
      for (int i = 0; i < issue_w; i++)
      begin
         rn_valid[i] = rn[i].valid;
         op_cnt[i]   = 3'(rn[i].dec.alu_op != ALU_NONE) + 3'(rn[i].dec.lpu_op != LPU_NONE)
                     + 3'(rn[i].dec.epu_op != EPU_NONE) + 3'(rn[i].dec.bru_op != BRU_NONE)
                     + 3'(rn[i].dec.lsu_op != LSU_NONE);
      end
   end

   a_no_pop_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      rn_stall_req |-> id_pop_cnt == '0)
   else
   begin
      $error("id_pop_cnt nonzero while rename stalls");
      fails++;
   end

   // Valids clear one edge after a flush or a sampled reset
   a_valid_clear: assert property (@(posedge clk)
      (flush || !rst_n) |=> rn_valid == '0)
   else
   begin
      $error("rn valid bits not cleared after flush or reset");
      fails++;
   end

   for (genvar i = 0; i < issue_w; i++)
   begin : gen_slot
      a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
         rn_valid[i] |-> op_cnt[i] <= 3'd1)
      else
      begin
         $error("rn slot %0d carries more than one unit op", i);
         fails++;
      end
   end

endmodule

bind id_stage id_stage_chk u_chk
(
   .clk          (clk),
   .rst_n        (rst_n),
   .flush        (flush),
   .rn_stall_req (rn_stall_req),
   .id_pop_cnt   (id_pop_cnt),
   .rn           (rn)
);

`default_nettype wire

// File: test/id_tb.sv
/*
 Decode stage testbench. Acts as fetch queue and rename, applies a table of
 slot inputs with expected count and decode, and checks rn one cycle later
*/
`timescale 1ns/100ps
`default_nettype none

module id_tb;
   import id_pkg::*;

   typedef struct {
      string                          name;
      logic [issue_w-1:0][insn_w-1:0] ins;
      logic [issue_w-1:0]             v;
      logic [issue_w-1:0]             e;
      dec_slot_t [issue_w-1:0]        d;
      logic [2:0]                     ctl;   // irq, stall, flush
      int                             cnt;
   } row_t;

   logic                         clk;
   logic                         rst_n;
   logic                         flush;
   logic                         rn_stall_req;
   logic                         irq_async;
   fnt_slot_t [issue_w-1:0]      fnt;
   logic [cnt_w-1:0]             id_pop_cnt;
   rn_slot_t [issue_w-1:0]       rn;
   row_t                         rows[$];
   int                           errors;
   int                           row_errs;
   // Expected stage register contents
   logic [issue_w-1:0]           exp_valid;
   logic [issue_w-1:0][pc_w-1:0] exp_pc;
   dec_slot_t [issue_w-1:0]      exp_dec;

   id_tb_clk u_clk (.clk(clk));

   id_stage uut
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .rn_stall_req (rn_stall_req),
      .irq_async    (irq_async),
      .fnt          (fnt),
      .id_pop_cnt   (id_pop_cnt),
      .rn           (rn)
   );

   // Encodings from the fixed field positions
   function automatic logic [31:0] r_ins(opcode_e op, int rd, int rs1, int rs2);
      return {11'b0, 5'(rs2), 5'(rs1), 5'(rd), op};
   endfunction

   function automatic logic [31:0] i_ins(opcode_e op, int rd, int rs1, logic [15:0] imm);
      return {imm, 5'(rs1), 5'(rd), op};
   endfunction

   // Expected decode, one per operand format
   function automatic dec_slot_t exp_r(alu_op_e a, lpu_op_e l, int rd, int rs1, int rs2);
      return '{a, l, EPU_NONE, BRU_NONE, LSU_NONE, '0,
               5'(rs1), 1'b1, 5'(rs2), 1'b1, 5'(rd), rd != 0};
   endfunction

   function automatic dec_slot_t exp_i(alu_op_e a, lsu_op_e s, int rd, int rs1, logic [15:0] imm);
      return '{a, LPU_NONE, EPU_NONE, BRU_NONE, s, {{16{imm[15]}}, imm},
               5'(rs1), 1'b1, '0, 1'b0, 5'(rd), rd != 0};
   endfunction

   // Second source comes from the rd field
   function automatic dec_slot_t exp_sb(bru_op_e b, lsu_op_e s, int rs2, int rs1, logic [15:0] imm);
      return '{ALU_NONE, LPU_NONE, EPU_NONE, b, s, {{16{imm[15]}}, imm},
               5'(rs1), 1'b1, 5'(rs2), 1'b1, '0, 1'b0};
   endfunction

   function automatic dec_slot_t exp_jal(logic [25:0] imm);
      return '{ALU_NONE, LPU_NONE, EPU_NONE, BRU_JAL, LSU_NONE, {{6{imm[25]}}, imm},
               '0, 1'b0, '0, 1'b0, 5'd1, 1'b1};
   endfunction

   function automatic dec_slot_t exp_epu(epu_op_e e);
      return '{ALU_NONE, LPU_NONE, e, BRU_NONE, LSU_NONE, '0, '0, 1'b0, '0, 1'b0, '0, 1'b0};
   endfunction

   function automatic logic [14:0] ctrl_of(dec_slot_t d);
      return {d.alu_op, d.lpu_op, d.epu_op, d.bru_op, d.lsu_op, d.lrs1_re, d.lrs2_re, d.lrd_we};
   endfunction

   // Register fields in use, zero where the enable is off
   function automatic logic [14:0] used_regs(dec_slot_t d);
      return {d.lrs1 & {5{d.lrs1_re}}, d.lrs2 & {5{d.lrs2_re}}, d.lrd & {5{d.lrd_we}}};
   endfunction

   task automatic add_row(string name, logic [2:0] ctl, int cnt,
                          logic v0, logic e0, logic [31:0] i0, dec_slot_t d0,
                          logic v1, logic e1, logic [31:0] i1, dec_slot_t d1);
      rows.push_back('{name, {i1, i0}, {v1, v0}, {e1, e0}, {d1, d0}, ctl, cnt});
   endtask

   // Same slots as the row before, new control
   task automatic repeat_row(string name, logic [2:0] ctl, int cnt);
      row_t r;
      r      = rows[$];
      r.name = name;
      r.ctl  = ctl;
      r.cnt  = cnt;
      rows.push_back(r);
   endtask

   task automatic check_val(string row, string what, logic [63:0] expected,
                            logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         $display("CHECK FAILED %s %s: expected %0h, actual %0h", row, what, expected, actual);
         row_errs++;
      end
   endtask

   task automatic check_slot(string row, int s);
      string tag;
      tag = $sformatf("slot%0d", s);
      check_val(row, {tag, " valid"}, exp_valid[s], rn[s].valid);
      if (exp_valid[s])
      begin
         check_val(row, {tag, " pc"}, exp_pc[s], rn[s].pc);
         check_val(row, {tag, " ops"}, ctrl_of(exp_dec[s]), ctrl_of(rn[s].dec));
         check_val(row, {tag, " regs"}, used_regs(exp_dec[s]), used_regs(rn[s].dec));
         // Immediate only matters when no EPU op replaced the instruction
         if (exp_dec[s].epu_op == EPU_NONE)
            check_val(row, {tag, " imm"}, exp_dec[s].imm, rn[s].dec.imm);
      end
   endtask

   initial
   begin
      row_t                         r;
      int                           n;
      logic                         held;
      logic [issue_w-1:0][pc_w-1:0] pc;
      errors       = 0;
      rst_n        = 1'b0;
      flush        = 1'b0;
      rn_stall_req = 1'b0;
      irq_async    = 1'b0;
      fnt          = '0;
      void'($urandom(32'h8865_0a1a));

      add_row("add_sub", 3'b000, 2,
              1, 0, r_ins(OP_ADD, 3, 4, 5), exp_r(ALU_ADD, LPU_NONE, 3, 4, 5),
              1, 0, r_ins(OP_SUB, 31, 1, 2), exp_r(ALU_SUB, LPU_NONE, 31, 1, 2));
      add_row("and_or", 3'b000, 2,
              1, 0, r_ins(OP_AND, 7, 8, 9), exp_r(ALU_AND, LPU_NONE, 7, 8, 9),
              1, 0, r_ins(OP_OR, 10, 11, 12), exp_r(ALU_OR, LPU_NONE, 10, 11, 12));
      add_row("xor_mul", 3'b000, 2,
              1, 0, r_ins(OP_XOR, 13, 14, 15), exp_r(ALU_XOR, LPU_NONE, 13, 14, 15),
              1, 0, r_ins(OP_MUL, 16, 17, 18),
              enable_mul ? exp_r(ALU_NONE, LPU_MUL, 16, 17, 18) : exp_epu(EPU_EXC_ILLEGAL));
      add_row("addi_ldw", 3'b000, 2,
              1, 0, i_ins(OP_ADDI, 2, 3, 16'hfff0), exp_i(ALU_ADD, LSU_NONE, 2, 3, 16'hfff0),
              1, 0, i_ins(OP_LDW, 4, 5, 16'h0040), exp_i(ALU_NONE, LSU_LDW, 4, 5, 16'h0040));
      add_row("stw_beq", 3'b000, 2,
              1, 0, i_ins(OP_STW, 6, 7, 16'h8000), exp_sb(BRU_NONE, LSU_STW, 6, 7, 16'h8000),
              1, 0, i_ins(OP_BEQ, 8, 9, 16'h0004), exp_sb(BRU_BEQ, LSU_NONE, 8, 9, 16'h0004));
      add_row("jal_syscall", 3'b000, 2,
              1, 0, {26'h3ff_fff0, OP_JAL}, exp_jal(26'h3ff_fff0),
              1, 0, r_ins(OP_SYSCALL, 0, 0, 0), exp_epu(EPU_SYSCALL));
      add_row("eret_div", 3'b000, 2,
              1, 0, r_ins(OP_ERET, 0, 0, 0), exp_epu(EPU_ERET),
              1, 0, r_ins(OP_DIV, 1, 2, 3),
              enable_div ? exp_r(ALU_NONE, LPU_DIV, 1, 2, 3) : exp_epu(EPU_EXC_ILLEGAL));
      add_row("r0_write", 3'b000, 2,
              1, 0, r_ins(OP_ADD, 0, 1, 2), exp_r(ALU_ADD, LPU_NONE, 0, 1, 2),
              1, 0, i_ins(OP_ADDI, 0, 4, 16'h0001), exp_i(ALU_ADD, LSU_NONE, 0, 4, 16'h0001));
      // Interrupt wins over the fetch fault on slot 0 and leaves slot 1 alone
      add_row("irq", 3'b100, 2,
              1, 1, r_ins(OP_ADD, 3, 4, 5), exp_epu(EPU_IRQ),
              1, 0, r_ins(OP_SUB, 5, 6, 7), exp_r(ALU_SUB, LPU_NONE, 5, 6, 7));
      add_row("faults", 3'b000, 2,
              1, 1, {26'h0, 6'h3f}, exp_epu(EPU_EXC_FETCH),
              1, 0, {26'h0, 6'h3f}, exp_epu(EPU_EXC_ILLEGAL));
      add_row("stall_new", 3'b010, 0,
              1, 0, r_ins(OP_AND, 1, 2, 3), exp_r(ALU_AND, LPU_NONE, 1, 2, 3),
              1, 0, r_ins(OP_XOR, 4, 5, 6), exp_r(ALU_XOR, LPU_NONE, 4, 5, 6));
      repeat_row("stall_hold", 3'b010, 0);
      repeat_row("release", 3'b000, 2);
      repeat_row("flush_stall", 3'b011, 0);
      repeat_row("flush", 3'b001, 2);
      add_row("single", 3'b000, 1,
              1, 0, r_ins(OP_OR, 2, 3, 4), exp_r(ALU_OR, LPU_NONE, 2, 3, 4),
              0, 0, r_ins(OP_ADD, 1, 1, 1), exp_epu(EPU_NONE));
      add_row("empty", 3'b000, 0,
              0, 0, r_ins(OP_SUB, 1, 1, 1), exp_epu(EPU_NONE),
              0, 0, r_ins(OP_ADD, 1, 1, 1), exp_epu(EPU_NONE));

      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      n     = 0;
      while ((rn[0].valid | rn[1].valid) !== 1'b0 && n < 16)
      begin
         @(negedge clk);
         n++;
      end
      if (n == 16)
      begin
         $display("rn valid bits still set after reset was released");
         $display("Something failed");
         $finish;
      end
      $display("%-12s ok", "reset");

      held = 1'b0;
      foreach (rows[i])
      begin
         r        = rows[i];
         row_errs = 0;
         // Fetch keeps presenting the same slots while rename stalls
         if (!held)
         begin
            pc[0] = pc_w'($urandom);
            pc[1] = pc_w'($urandom);
         end
         held = r.ctl[1];
         for (int s = 0; s < issue_w; s++)
            fnt[s] = '{r.v[s], r.ins[s], pc[s], r.e[s]};
         {irq_async, rn_stall_req, flush} = r.ctl;
         #1;
         check_val(r.name, "id_pop_cnt", r.cnt, id_pop_cnt);
         @(posedge clk);
         if (!r.ctl[1])
         begin
            exp_valid = r.v;
            exp_pc    = pc;
            exp_dec   = r.d;
         end
         if (r.ctl[0])
            exp_valid = '0;
         @(negedge clk);
         for (int s = 0; s < issue_w; s++)
            check_slot(r.name, s);
         errors += row_errs;
         $display("%-12s %s", r.name, (row_errs == 0) ? "ok" : "mismatch");
      end

      errors += uut.u_chk.fails;
      $display("rows run: %0d, checks failed: %0d", rows.size(), errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
hdl/id_pkg.sv
hdl/id_dec.sv
hdl/id_pipe_reg.sv
hdl/id_stage.sv
test/id_tb_clk.sv
test/id_stage_chk.sv
test/id_tb.sv
